// File: src/cpuPkg.sv
/*
 * CPU package for the MIPS32 decode stage.
 * Word and field typedefs, the control enums passed from the decoder
 * toward execute, memory and write-back, and the opcode/funct encodings
 * of the supported instruction subset.
 */
`default_nettype none

package cpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [15:0] imm16_t;

    // immediate extension kind
    typedef enum logic [1:0] {
        EXT_ZERO  = 2'd0,
        EXT_SIGN  = 2'd1,
        EXT_UPPER = 2'd2   // lui, imm in [31:16]
    } extOp_t;

    // busB source, same order as the old 4-to-1 mux
    typedef enum logic [1:0] {
        RD_RF  = 2'd0,
        RD_HI  = 2'd1,
        RD_LO  = 2'd2,
        RD_CP0 = 2'd3
    } readSel_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLT = 3'd5,
        ALU_SLL = 3'd6,
        ALU_LUI = 3'd7
    } aluOp_t;

    typedef enum logic [1:0] {
        DST_RD  = 2'd0,
        DST_RT  = 2'd1,
        DST_R31 = 2'd2
    } dstSel_t;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_PC8 = 2'd2   // link address for jal
    } wbSel_t;

    typedef enum logic [1:0] {
        BR_NONE = 2'd0,
        BR_BEQ  = 2'd1,
        BR_BNE  = 2'd2,
        BR_JUMP = 2'd3
    } branch_t;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_LUI     = 6'h0f;
    localparam logic [5:0] OP_COP0    = 6'h10;
    localparam logic [5:0] OP_LW      = 6'h23;
    localparam logic [5:0] OP_SW      = 6'h2b;

    // SPECIAL funct codes
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_MFHI = 6'h10;
    localparam logic [5:0] FN_MFLO = 6'h12;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    localparam logic [4:0] RS_MFC0 = 5'h00;   // COP0 sub-op in rs field

    localparam word_t NOP_INSTR = 32'h0000_0000;   // sll r0, r0, 0

endpackage

`default_nettype wire

// File: src/idPipeReg.sv
/*
 * IF/ID pipeline register.
 * Captures the fetched instruction and its PC. Reset and flush load a
 * NOP with PC 0, idWr low holds the current entry (stall). The field
 * outputs are slices of the held instruction word.
 */
`default_nettype none
`timescale 1ns/1ps

module idPipeReg (
    input  logic              clk,
    input  logic              rst,
    input  logic              idFlush,
    input  logic              idWr,      // stall when low
    input  cpuPkg::word_t     ifInstr,
    input  cpuPkg::word_t     ifPc,
    output cpuPkg::word_t     idInstr,
    output cpuPkg::word_t     idPc,
    output cpuPkg::regAddr_t  rs,
    output cpuPkg::regAddr_t  rt,
    output cpuPkg::regAddr_t  rd,
    output logic [4:0]        shamt,
    output cpuPkg::imm16_t    imm16
);
    import cpuPkg::*;

    word_t instrQ;
    word_t pcQ;

    // flush wins over stall
    always_ff @(posedge clk) begin
        if (rst || idFlush) begin
            instrQ <= NOP_INSTR;
            pcQ    <= '0;
        end else if (idWr) begin
            instrQ <= ifInstr;
            pcQ    <= ifPc;
        end
    end

    assign idInstr = instrQ;
    assign idPc    = pcQ;

    // fixed MIPS field positions
    assign rs    = instrQ[25:21];
    assign rt    = instrQ[20:16];
    assign rd    = instrQ[15:11];
    assign shamt = instrQ[10:6];
    assign imm16 = instrQ[15:0];

endmodule

`default_nettype wire

// File: src/regFile.sv
/*
 * General purpose register file, 32 x 32 bit.
 * One synchronous write port from write-back and two asynchronous read
 * ports for rs and rt. A read of the register being written in the same
 * cycle returns the write-back value, so WB-to-ID needs no stall.
 * Register 0 is hardwired to zero.
 */
`default_nettype none
`timescale 1ns/1ps

module regFile (
    input  logic              clk,
    input  logic              rst,
    input  logic              wbRfWr,
    input  cpuPkg::regAddr_t  wbDst,
    input  cpuPkg::word_t     wbResult,
    input  cpuPkg::regAddr_t  rs,
    input  cpuPkg::regAddr_t  rt,
    output cpuPkg::word_t     rfBusA,
    output cpuPkg::word_t     rfBusB
);
    import cpuPkg::*;

    word_t regs [32];

    // one read port with write-back bypass
    function automatic word_t readPort(input regAddr_t addr);
        word_t val;
        if (addr == '0) begin
            val = '0;                                   // r0 always zero
        end else if (wbRfWr && (wbDst == addr)) begin
            val = wbResult;                             // WB-to-ID bypass
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbRfWr && (wbDst != '0)) begin
            regs[wbDst] <= wbResult;
        end
    end

    always_comb begin
        rfBusA = readPort(rs);
        rfBusB = readPort(rt);
    end

endmodule

`default_nettype wire

// File: src/instrDecoder.sv
/*
 * Main control decoder.
 * Maps the held instruction word to execute, memory and write-back
 * controls. SPECIAL is decoded by funct and COP0 by the rs field.
 * Anything outside the supported subset raises exceptRi with all
 * write and memory controls low.
 */
`default_nettype none
`timescale 1ns/1ps

module instrDecoder (
    input  cpuPkg::word_t     idInstr,
    output cpuPkg::aluOp_t    aluOp,
    output logic              aluSrcImm,   // operand B from imm32
    output cpuPkg::dstSel_t   dstSel,
    output logic              regWrite,
    output cpuPkg::wbSel_t    wbSel,
    output logic              memRead,
    output logic              memWrite,
    output cpuPkg::branch_t   branchType,
    output logic              isImmJump,   // j / jal target from instr_index
    output cpuPkg::extOp_t    extOp,
    output cpuPkg::readSel_t  readSel,
    output logic [1:0]        rsrtRead,    // [1] rs used, [0] rt used
    output logic              exceptRi
);
    import cpuPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regAddr_t   rsField;
    regAddr_t   dstNum;
    logic       wrEn;                      // write before r0 suppression

    assign opcode  = idInstr[31:26];
    assign funct   = idInstr[5:0];
    assign rsField = idInstr[25:21];

    always_comb begin
        aluOp      = ALU_ADD;
        aluSrcImm  = 1'b0;
        dstSel     = DST_RD;
        wrEn       = 1'b0;
        wbSel      = WB_ALU;
        memRead    = 1'b0;
        memWrite   = 1'b0;
        branchType = BR_NONE;
        isImmJump  = 1'b0;
        extOp      = EXT_ZERO;
        readSel    = RD_RF;
        rsrtRead   = 2'b00;
        exceptRi   = 1'b0;

        case (opcode)
            OP_SPECIAL: begin
                wrEn     = 1'b1;
                rsrtRead = 2'b11;
                case (funct)
                    FN_ADDU: aluOp = ALU_ADD;
                    FN_SUBU: aluOp = ALU_SUB;
                    FN_AND:  aluOp = ALU_AND;
                    FN_OR:   aluOp = ALU_OR;
                    FN_XOR:  aluOp = ALU_XOR;
                    FN_SLT:  aluOp = ALU_SLT;
                    FN_SLL: begin
                        aluOp    = ALU_SLL;
                        rsrtRead = 2'b01;      // shifts rt by shamt
                    end
                    FN_MFHI: begin
                        aluOp    = ALU_OR;     // busA is r0, passes busB
                        readSel  = RD_HI;
                        rsrtRead = 2'b00;
                    end
                    FN_MFLO: begin
                        aluOp    = ALU_OR;
                        readSel  = RD_LO;
                        rsrtRead = 2'b00;
                    end
                    default: begin
                        wrEn     = 1'b0;
                        rsrtRead = 2'b00;
                        exceptRi = 1'b1;
                    end
                endcase
            end
            OP_COP0: begin
                if (rsField == RS_MFC0) begin
                    aluOp   = ALU_OR;
                    dstSel  = DST_RT;
                    readSel = RD_CP0;
                    wrEn    = 1'b1;
                end else begin
                    exceptRi = 1'b1;
                end
            end
            OP_ADDIU, OP_ANDI, OP_ORI: begin
                aluSrcImm = 1'b1;
                dstSel    = DST_RT;
                wrEn      = 1'b1;
                rsrtRead  = 2'b10;
                if (opcode == OP_ADDIU) begin
                    aluOp = ALU_ADD;
                    extOp = EXT_SIGN;
                end else if (opcode == OP_ANDI) begin
                    aluOp = ALU_AND;
                end else begin
                    aluOp = ALU_OR;
                end
            end
            OP_LUI: begin
                aluOp     = ALU_LUI;
                aluSrcImm = 1'b1;
                extOp     = EXT_UPPER;
                dstSel    = DST_RT;
                wrEn      = 1'b1;
            end
            OP_LW: begin
                aluSrcImm = 1'b1;
                extOp     = EXT_SIGN;
                dstSel    = DST_RT;
                wrEn      = 1'b1;
                wbSel     = WB_MEM;
                memRead   = 1'b1;
                rsrtRead  = 2'b10;
            end
            OP_SW: begin
                aluSrcImm = 1'b1;
                extOp     = EXT_SIGN;
                memWrite  = 1'b1;
                rsrtRead  = 2'b11;             // rt is store data
            end
            OP_BEQ, OP_BNE: begin
                aluOp      = ALU_SUB;
                extOp      = EXT_SIGN;         // branch offset
                rsrtRead   = 2'b11;
                branchType = (opcode == OP_BEQ) ? BR_BEQ : BR_BNE;
            end
            OP_J, OP_JAL: begin
                branchType = BR_JUMP;
                isImmJump  = 1'b1;
                if (opcode == OP_JAL) begin
                    dstSel = DST_R31;
                    wbSel  = WB_PC8;
                    wrEn   = 1'b1;
                end
            end
            default: exceptRi = 1'b1;
        endcase
    end

    // resolved destination, writes to r0 are dropped here
    always_comb begin
        case (dstSel)
            DST_RT:  dstNum = idInstr[20:16];
            DST_R31: dstNum = 5'd31;
            default: dstNum = idInstr[15:11];
        endcase
    end

    assign regWrite = wrEn && (dstNum != '0);

endmodule

`default_nettype wire

// File: src/idOperands.sv
/*
 * Decode-stage operand logic.
 * Builds imm32 from the 16-bit immediate (zero, sign or upper-half)
 * and picks busB from the register file, HI, LO or CP0 for the
 * move-from instructions.
 */
`default_nettype none
`timescale 1ns/1ps

module idOperands (
    input  cpuPkg::imm16_t    imm16,
    input  cpuPkg::extOp_t    extOp,
    input  cpuPkg::word_t     rfBusB,
    input  cpuPkg::word_t     hiBus,
    input  cpuPkg::word_t     loBus,
    input  cpuPkg::word_t     cp0Bus,
    input  cpuPkg::readSel_t  readSel,
    output cpuPkg::word_t     imm32,
    output cpuPkg::word_t     busB
);
    import cpuPkg::*;

    always_comb begin
        case (extOp)
            EXT_SIGN:  imm32 = {{16{imm16[15]}}, imm16};
            EXT_UPPER: imm32 = {imm16, 16'h0000};
            default:   imm32 = {16'h0000, imm16};    // andi, ori
        endcase
    end

    // busB source, rf is already bypassed
    always_comb begin
        case (readSel)
            RD_HI:   busB = hiBus;
            RD_LO:   busB = loBus;
            RD_CP0:  busB = cp0Bus;
            default: busB = rfBusB;
        endcase
    end

endmodule

`default_nettype wire

// File: src/idStage.sv
/*
 * Instruction decode stage top.
 * IF/ID register, register file with WB bypass, control decoder and
 * operand logic of the MIPS32 pipeline. Everything after the IF/ID
 * register is combinational.
 */
`default_nettype none
`timescale 1ns/1ps

module idStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              idFlush,
    input  logic              idWr,
    input  cpuPkg::word_t     ifInstr,
    input  cpuPkg::word_t     ifPc,
    input  logic              wbRfWr,      // write-back port
    input  cpuPkg::regAddr_t  wbDst,
    input  cpuPkg::word_t     wbResult,
    input  cpuPkg::word_t     hiBus,
    input  cpuPkg::word_t     loBus,
    input  cpuPkg::word_t     cp0Bus,
    output cpuPkg::word_t     idPc,
    output cpuPkg::word_t     idInstr,
    output cpuPkg::regAddr_t  rs,
    output cpuPkg::regAddr_t  rt,
    output cpuPkg::regAddr_t  rd,
    output logic [4:0]        shamt,
    output cpuPkg::word_t     busA,
    output cpuPkg::word_t     busB,
    output cpuPkg::word_t     imm32,
    output cpuPkg::aluOp_t    aluOp,
    output logic              aluSrcImm,
    output cpuPkg::dstSel_t   dstSel,
    output logic              regWrite,
    output cpuPkg::wbSel_t    wbSel,
    output logic              memRead,
    output logic              memWrite,
    output cpuPkg::branch_t   branchType,
    output logic              isImmJump,   // for pc select
    output logic [1:0]        rsrtRead,    // for hazard unit
    output logic              exceptRi
);
    import cpuPkg::*;

    imm16_t   imm16;
    word_t    rfBusB;
    extOp_t   extOp;
    readSel_t readSel;

    idPipeReg u_idPipeReg (
        .clk      (clk),
        .rst      (rst),
        .idFlush  (idFlush),
        .idWr     (idWr),
        .ifInstr  (ifInstr),
        .ifPc     (ifPc),
        .idInstr  (idInstr),
        .idPc     (idPc),
        .rs       (rs),
        .rt       (rt),
        .rd       (rd),
        .shamt    (shamt),
        .imm16    (imm16)
    );

    regFile u_regFile (
        .clk      (clk),
        .rst      (rst),
        .wbRfWr   (wbRfWr),
        .wbDst    (wbDst),
        .wbResult (wbResult),
        .rs       (rs),
        .rt       (rt),
        .rfBusA   (busA),     // bypassed, goes straight out
        .rfBusB   (rfBusB)
    );

    instrDecoder u_instrDecoder (
        .idInstr    (idInstr),
        .aluOp      (aluOp),
        .aluSrcImm  (aluSrcImm),
        .dstSel     (dstSel),
        .regWrite   (regWrite),
        .wbSel      (wbSel),
        .memRead    (memRead),
        .memWrite   (memWrite),
        .branchType (branchType),
        .isImmJump  (isImmJump),
        .extOp      (extOp),
        .readSel    (readSel),
        .rsrtRead   (rsrtRead),
        .exceptRi   (exceptRi)
    );

    idOperands u_idOperands (
        .imm16    (imm16),
        .extOp    (extOp),
        .rfBusB   (rfBusB),
        .hiBus    (hiBus),
        .loBus    (loBus),
        .cp0Bus   (cp0Bus),
        .readSel  (readSel),
        .imm32    (imm32),
        .busB     (busB)
    );

endmodule

`default_nettype wire

// File: sim/clkGen.sv
/*
 * Testbench clock and reset.
 * 4 ns clock; reset is held high for the first three rising edges.
 */
`default_nettype none
`timescale 1ns/1ps

module clkGen (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;    // released on the third edge
    end

endmodule

`default_nettype wire

// File: sim/idStage_checker.sv
/*
 * Decode-stage assertions, bound into idStage.
 * Flush loads a NOP, a stall holds the IF/ID register, and a reserved
 * instruction never writes a register or touches memory.
 */
`default_nettype none
`timescale 1ns/1ps

module idStage_checker (
    input logic          clk,
    input logic          rst,
    input logic          idFlush,
    input logic          idWr,
    input cpuPkg::word_t idInstr,
    input logic          regWrite,
    input logic          memRead,
    input logic          memWrite,
    input logic          exceptRi
);
    import cpuPkg::*;

    // flush lands on the next edge
    aFlushNop: assert property (@(posedge clk) idFlush |=> (idInstr == NOP_INSTR))
        else $error("idInstr is not a NOP one cycle after a flush");

    aStallHold: assert property (@(posedge clk)
        (!idWr && !rst && !idFlush) |=> $stable(idInstr))
        else $error("idInstr changed while the IF/ID register was stalled");

    aRiQuiet: assert property (@(posedge clk)
        exceptRi |-> !(regWrite || memRead || memWrite))
        else $error("reserved instruction drives a write or memory control");

endmodule

bind idStage idStage_checker u_checker (
    .clk      (clk),
    .rst      (rst),
    .idFlush  (idFlush),
    .idWr     (idWr),
    .idInstr  (idInstr),
    .regWrite (regWrite),
    .memRead  (memRead),
    .memWrite (memWrite),
    .exceptRi (exceptRi)
);

`default_nettype wire

// File: sim/idStageTb.sv
/*
 * Directed testbench for the MIPS32 decode stage.
 * Covers reset, register file access and WB bypass, the decode table
 * of the supported subset, immediates and busB sources, stall and
 * flush. Expected values come from a local table of MIPS semantics.
 */
`default_nettype none
`timescale 1ns/1ps

module idStageTb;
    import cpuPkg::*;

    localparam int TIMEOUT = 16;    // cycles per wait

    logic       clk;
    logic       rst;
    logic       idFlush;
    logic       idWr;
    logic       wbRfWr;
    regAddr_t   wbDst;
    word_t      ifInstr;
    word_t      ifPc;
    word_t      wbResult;
    word_t      hiBus;
    word_t      loBus;
    word_t      cp0Bus;
    word_t      idPc;
    word_t      idInstr;
    regAddr_t   rs;
    regAddr_t   rt;
    regAddr_t   rd;
    logic [4:0] shamt;
    word_t      busA;
    word_t      busB;
    word_t      imm32;
    aluOp_t     aluOp;
    logic       aluSrcImm;
    dstSel_t    dstSel;
    logic       regWrite;
    wbSel_t     wbSel;
    logic       memRead;
    logic       memWrite;
    branch_t    branchType;
    logic       isImmJump;
    logic [1:0] rsrtRead;
    logic       exceptRi;

    int     errors;
    int     checks;
    integer seed;

    clkGen u_clkGen (.clk(clk), .rst(rst));

    idStage u_dut (.*);

    task automatic recordCheck(input string name, input logic ok, input word_t exp,
                               input word_t act);
        checks++;
        if (!ok) begin
            errors++;
            $display("ERR %s exp=%h got=%h", name, exp, act);
        end
    endtask

    task automatic checkWord(input string name, input word_t exp, input word_t act);
        recordCheck(name, act === exp, exp, act);
    endtask

    task automatic checkReg(input string name, input regAddr_t exp, input regAddr_t act);
        recordCheck(name, act === exp, word_t'(exp), word_t'(act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        recordCheck(name, act === exp, word_t'(exp), word_t'(act));
    endtask

    task automatic checkAlu(input string name, input aluOp_t exp, input aluOp_t act);
        recordCheck(name, act === exp, word_t'(exp), word_t'(act));
    endtask

    task automatic checkSel(input string name, input readSel_t exp, input readSel_t act);
        recordCheck(name, act === exp, word_t'(exp), word_t'(act));
    endtask

    task automatic checkBr(input string name, input branch_t exp, input branch_t act);
        recordCheck(name, act === exp, word_t'(exp), word_t'(act));
    endtask

    task automatic checkDst(input string name, input dstSel_t exp, input dstSel_t act);
        recordCheck(name, act === exp, word_t'(exp), word_t'(act));
    endtask

    task automatic checkWb(input string name, input wbSel_t exp, input wbSel_t act);
        recordCheck(name, act === exp, word_t'(exp), word_t'(act));
    endtask

    task automatic endTest(input string name, input int errsBefore);
        if (errors == errsBefore) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d error(s)", name, errors - errsBefore);
        end
    endtask

    function automatic word_t rType(input regAddr_t s, input regAddr_t t, input regAddr_t d,
                                    input logic [5:0] fn);
        return {OP_SPECIAL, s, t, d, 5'd0, fn};
    endfunction

    // rs is always r1
    function automatic word_t iType(input logic [5:0] op, input regAddr_t t, input imm16_t imm);
        return {op, 5'd1, t, imm};
    endfunction

    function automatic word_t regOp(input logic [5:0] fn);
        return rType(5'd1, 5'd2, 5'd3, fn);
    endfunction

    function automatic word_t immOp(input logic [5:0] op);
        return iType(op, 5'd4, 16'h8001);
    endfunction

    task automatic waitInstr(input word_t instr);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (idInstr !== instr && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (idInstr !== instr) begin
            errors++;
            $display("timeout: idInstr never became %h", instr);
        end
    endtask

    task automatic waitReset();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (rst !== 1'b0 && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (rst !== 1'b0) begin
            errors++;
            $display("timeout: reset was never released");
        end
    endtask

    // fetch hands over one instruction, returns once it is decoded
    task automatic issueInstr(input word_t instr);
        @(posedge clk);
        ifInstr <= instr;
        ifPc    <= ifPc + 32'd4;
        idWr    <= 1'b1;
        waitInstr(instr);
    endtask

    task automatic writeReg(input regAddr_t dst, input word_t val);
        @(posedge clk);
        wbRfWr   <= 1'b1;
        wbDst    <= dst;
        wbResult <= val;
    endtask

    task automatic stopWrite();
        @(posedge clk);
        wbRfWr <= 1'b0;
    endtask

    task automatic checkNopState(input string tag);
        checkWord({tag, " idInstr"}, NOP_INSTR, idInstr);
        checkWord({tag, " idPc"}, 32'h0, idPc);
        checkBit({tag, " regWrite"}, 1'b0, regWrite);
        checkBit({tag, " memRead"}, 1'b0, memRead);
        checkBit({tag, " memWrite"}, 1'b0, memWrite);
        checkBit({tag, " isImmJump"}, 1'b0, isImmJump);
        checkBit({tag, " exceptRi"}, 1'b0, exceptRi);
        checkBr({tag, " branchType"}, BR_NONE, branchType);
    endtask

    task automatic resetState();
        int errsBefore;
        errsBefore = errors;
        waitReset();
        checkNopState("reset");
        endTest("reset state", errsBefore);
    endtask

    task automatic regReadWrite();
        int    errsBefore;
        word_t vals [4];
        errsBefore = errors;
        for (int i = 0; i < 4; i++) begin
            vals[i] = $random(seed);
            writeReg(regAddr_t'(i + 1), vals[i]);
        end
        writeReg(5'd0, $random(seed));    // r0 must drop this
        stopWrite();
        issueInstr(rType(5'd1, 5'd2, 5'd10, FN_ADDU));
        checkReg("rs field", 5'd1, rs);
        checkReg("rt field", 5'd2, rt);
        checkReg("rd field", 5'd10, rd);
        checkWord("busA r1", vals[0], busA);
        checkWord("busB r2", vals[1], busB);
        issueInstr(rType(5'd3, 5'd4, 5'd10, FN_ADDU));
        checkWord("busA r3", vals[2], busA);
        checkWord("busB r4", vals[3], busB);
        issueInstr(rType(5'd0, 5'd0, 5'd10, FN_ADDU));
        checkWord("busA r0", 32'h0, busA);
        checkWord("busB r0", 32'h0, busB);
        endTest("register file", errsBefore);
    endtask

    task automatic wbBypass();
        int    errsBefore;
        word_t val;
        errsBefore = errors;
        val = $random(seed);
        issueInstr(rType(5'd5, 5'd5, 5'd6, FN_ADDU));
        checkWord("busA r5 before write", 32'h0, busA);
        writeReg(5'd5, val);
        @(negedge clk);
        checkWord("busA bypass", val, busA);    // same cycle as the write
        checkWord("busB bypass", val, busB);
        stopWrite();
        @(negedge clk);
        checkWord("busA stored", val, busA);
        endTest("wb bypass", errsBefore);
    endtask

    // flags are {memRead, memWrite, regWrite, isImmJump, exceptRi}
    task automatic decodeCase(input string tag, input word_t instr, input aluOp_t expAlu,
                              input dstSel_t expDst, input wbSel_t expWb,
                              input branch_t expBr, input logic [4:0] flags,
                              input logic [1:0] expRsrt);
        issueInstr(instr);
        checkAlu({tag, " aluOp"}, expAlu, aluOp);
        checkDst({tag, " dstSel"}, expDst, dstSel);
        checkWb({tag, " wbSel"}, expWb, wbSel);
        checkBr({tag, " branchType"}, expBr, branchType);
        checkBit({tag, " memRead"}, flags[4], memRead);
        checkBit({tag, " memWrite"}, flags[3], memWrite);
        checkBit({tag, " regWrite"}, flags[2], regWrite);
        checkBit({tag, " isImmJump"}, flags[1], isImmJump);
        checkBit({tag, " exceptRi"}, flags[0], exceptRi);
        checkBit({tag, " rsRead"}, expRsrt[1], rsrtRead[1]);
        checkBit({tag, " rtRead"}, expRsrt[0], rsrtRead[0]);
    endtask

    task automatic decodeTable();
        int    errsBefore;
        word_t mfc0Instr;
        word_t toR0;
        errsBefore = errors;
        mfc0Instr = {OP_COP0, RS_MFC0, 5'd4, 5'd12, 11'd0};
        toR0 = rType(5'd1, 5'd2, 5'd0, FN_ADDU);
        decodeCase("addu", regOp(FN_ADDU), ALU_ADD, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b11);
        decodeCase("subu", regOp(FN_SUBU), ALU_SUB, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b11);
        decodeCase("and", regOp(FN_AND), ALU_AND, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b11);
        decodeCase("or", regOp(FN_OR), ALU_OR, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b11);
        decodeCase("xor", regOp(FN_XOR), ALU_XOR, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b11);
        decodeCase("slt", regOp(FN_SLT), ALU_SLT, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b11);
        decodeCase("sll", regOp(FN_SLL), ALU_SLL, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b01);
        // shift amount field
        issueInstr({OP_SPECIAL, 5'd0, 5'd2, 5'd3, 5'd17, FN_SLL});
        checkReg("sll shamt", 5'd17, shamt);
        decodeCase("mfhi", regOp(FN_MFHI), ALU_OR, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b00);
        decodeCase("mflo", regOp(FN_MFLO), ALU_OR, DST_RD, WB_ALU, BR_NONE, 5'b00100, 2'b00);
        decodeCase("addiu", immOp(OP_ADDIU), ALU_ADD, DST_RT, WB_ALU, BR_NONE, 5'b00100, 2'b10);
        decodeCase("andi", immOp(OP_ANDI), ALU_AND, DST_RT, WB_ALU, BR_NONE, 5'b00100, 2'b10);
        decodeCase("ori", immOp(OP_ORI), ALU_OR, DST_RT, WB_ALU, BR_NONE, 5'b00100, 2'b10);
        decodeCase("lui", immOp(OP_LUI), ALU_LUI, DST_RT, WB_ALU, BR_NONE, 5'b00100, 2'b00);
        decodeCase("lw", immOp(OP_LW), ALU_ADD, DST_RT, WB_MEM, BR_NONE, 5'b10100, 2'b10);
        decodeCase("sw", immOp(OP_SW), ALU_ADD, DST_RD, WB_ALU, BR_NONE, 5'b01000, 2'b11);
        decodeCase("beq", immOp(OP_BEQ), ALU_SUB, DST_RD, WB_ALU, BR_BEQ, 5'b00000, 2'b11);
        decodeCase("bne", immOp(OP_BNE), ALU_SUB, DST_RD, WB_ALU, BR_BNE, 5'b00000, 2'b11);
        decodeCase("j", {OP_J, 26'h400}, ALU_ADD, DST_RD, WB_ALU, BR_JUMP, 5'b00010, 2'b00);
        decodeCase("jal", {OP_JAL, 26'h400}, ALU_ADD, DST_R31, WB_PC8, BR_JUMP, 5'b00110, 2'b00);
        decodeCase("mfc0", mfc0Instr, ALU_OR, DST_RT, WB_ALU, BR_NONE, 5'b00100, 2'b00);
        decodeCase("addu r0", toR0, ALU_ADD, DST_RD, WB_ALU, BR_NONE, 5'b00000, 2'b11);
        // reserved opcode and reserved funct
        decodeCase("op 3f", {6'h3f, 26'h0}, ALU_ADD, DST_RD, WB_ALU, BR_NONE, 5'b00001, 2'b00);
        decodeCase("fn 3f", regOp(6'h3f), ALU_ADD, DST_RD, WB_ALU, BR_NONE, 5'b00001, 2'b00);
        endTest("decode table", errsBefore);
    endtask

    task automatic immCase(input string tag, input word_t instr, input word_t expImm);
        issueInstr(instr);
        checkWord({tag, " imm32"}, expImm, imm32);
        checkBit({tag, " aluSrcImm"}, 1'b1, aluSrcImm);
    endtask

    task automatic moveCase(input string tag, input word_t instr, input readSel_t expSel,
                            input word_t expVal);
        issueInstr(instr);
        checkSel({tag, " readSel"}, expSel, u_dut.readSel);
        checkWord({tag, " busB"}, expVal, busB);
        checkBit({tag, " aluSrcImm"}, 1'b0, aluSrcImm);
    endtask

    task automatic operands();
        int    errsBefore;
        word_t hiVal;
        word_t loVal;
        word_t cp0Val;
        errsBefore = errors;
        hiVal  = $random(seed);
        loVal  = $random(seed);
        cp0Val = $random(seed);
        @(posedge clk);
        hiBus  <= hiVal;
        loBus  <= loVal;
        cp0Bus <= cp0Val;
        immCase("addiu", iType(OP_ADDIU, 5'd4, 16'hfff0), 32'hffff_fff0);
        immCase("lw", iType(OP_LW, 5'd4, 16'h8004), 32'hffff_8004);
        immCase("andi", iType(OP_ANDI, 5'd4, 16'hf00f), 32'h0000_f00f);
        immCase("ori", iType(OP_ORI, 5'd4, 16'h8001), 32'h0000_8001);
        immCase("lui", iType(OP_LUI, 5'd4, 16'h1234), 32'h1234_0000);
        moveCase("mfhi", rType(5'd0, 5'd0, 5'd3, FN_MFHI), RD_HI, hiVal);
        moveCase("mflo", rType(5'd0, 5'd0, 5'd3, FN_MFLO), RD_LO, loVal);
        moveCase("mfc0", {OP_COP0, RS_MFC0, 5'd4, 5'd12, 11'd0}, RD_CP0, cp0Val);
        endTest("operands", errsBefore);
    endtask

    task automatic stallFlush();
        int    errsBefore;
        word_t held;
        word_t heldPc;
        errsBefore = errors;
        held = iType(OP_LW, 5'd7, 16'h0010);
        issueInstr(held);
        heldPc = ifPc;    // pc handed over with the held instruction
        checkWord("issue idPc", heldPc, idPc);
        @(posedge clk);
        idWr    <= 1'b0;
        ifInstr <= iType(OP_SW, 5'd8, 16'h0020);
        ifPc    <= ifPc + 32'd4;
        for (int i = 0; i < 3; i++) begin
            @(negedge clk);
            checkWord("stall idInstr", held, idInstr);
            checkWord("stall idPc", heldPc, idPc);
            checkBit("stall memRead", 1'b1, memRead);
            checkBit("stall memWrite", 1'b0, memWrite);
        end
        @(posedge clk);
        idFlush <= 1'b1;    // flush beats the write enable
        idWr    <= 1'b1;
        waitInstr(NOP_INSTR);
        checkNopState("flush");
        @(posedge clk);
        idFlush <= 1'b0;
        idWr    <= 1'b0;
        endTest("stall and flush", errsBefore);
    endtask

    initial begin
        seed     = 32'hde68;
        errors   = 0;
        checks   = 0;
        idFlush  <= 1'b0;
        idWr     <= 1'b0;
        wbRfWr   <= 1'b0;
        wbDst    <= 5'd0;
        wbResult <= 32'h0;
        ifInstr  <= NOP_INSTR;
        ifPc     <= 32'h0040_0000;
        hiBus    <= 32'h0;
        loBus    <= 32'h0;
        cp0Bus   <= 32'h0;

        resetState();
        regReadWrite();
        wbBypass();
        decodeTable();
        operands();
        stallFlush();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: idStage.f
src/cpuPkg.sv
src/idPipeReg.sv
src/regFile.sv
src/instrDecoder.sv
src/idOperands.sv
src/idStage.sv
sim/clkGen.sv
sim/idStage_checker.sv
sim/idStageTb.sv

// File: run.sh
#!/bin/sh
# build the decode-stage testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module idStageTb -f idStage.f -o idStageSim

# pass or fail comes from the log, not from the exit status
./obj_dir/idStageSim 2>&1 | tee sim.log

if grep -q "^TB PASSED$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
